// ==== rtl/clkgn_settings.svh ====
// --------------------------------------------------------------------
// clock divider control block, shared widths and constants
// ratio and stretch widths, apb bus sizes, start sync depth
// --------------------------------------------------------------------

`ifndef CLKGN_SETTINGS_SVH
`define CLKGN_SETTINGS_SVH

// divide ratio width, ratios run from min up to 15
`define CLKGN_RATIO_W 4

// smallest ratio the csr accepts
`define CLKGN_RATIO_MIN 2

// stretch count width, 0 means no stretch
`define CLKGN_STRETCH_W 4

// apb bus
`define CLKGN_APB_AW 8
`define CLKGN_APB_DW 32

// flops in the start synchronizer
`define CLKGN_SYNC_STAGES 2

// cmp, jbus, dram
`define CLKGN_NUM_DOM 3

`endif

// ==== rtl/clkgn_pkg.sv ====
// --------------------------------------------------------------------
// clkgn package
// register map, fsm state and ctrl bit position enums
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

package clkgn_pkg;

  // apb register map, word aligned
  typedef enum logic [`CLKGN_APB_AW-1:0] {
    REG_CDIV    = 'h00,
    REG_DDIV    = 'h04,
    REG_JDIV    = 'h08,
    REG_STRETCH = 'h0C,
    REG_CTRL    = 'h10
  } reg_addr_e;

  // start sequencer
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_SYNC, SEQ_RUN} seq_state_e;

  // stretch controller
  typedef enum logic [0:0] {STR_IDLE, STR_HOLD} str_state_e;

  // bit positions inside REG_CTRL
  typedef enum logic [2:0] {
    CTRL_START   = 3'd0,
    CTRL_CMP_EN  = 3'd1,
    CTRL_JBUS_EN = 3'd2,
    CTRL_DRAM_EN = 3'd3,
    CTRL_STRETCH = 3'd4
  } ctrl_bit_e;

endpackage

// ==== rtl/clkgn_csr_apb.sv ====
// --------------------------------------------------------------------
// apb slave register file
// divide ratios, stretch count, ctrl bits, stretch request pulse
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

module clkgn_csr_apb (
  input  logic                       ctu_clsp,
  input  logic                       arst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`CLKGN_APB_AW-1:0]   paddr,
  input  logic [`CLKGN_APB_DW-1:0]   pwdata,
  output logic [`CLKGN_APB_DW-1:0]   prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic [`CLKGN_RATIO_W-1:0]  cdiv,
  output logic [`CLKGN_RATIO_W-1:0]  ddiv,
  output logic [`CLKGN_RATIO_W-1:0]  jdiv,
  output logic [`CLKGN_STRETCH_W-1:0] stretch_cnt,
  output logic                       start,
  output logic                       cmp_en,
  output logic                       jbus_en,
  output logic                       dram_en,
  output logic                       stretch_req
);

  logic                      acc;
  logic                      wr_ok;
  logic                      addr_hit;
  logic                      ratio_bad;
  logic [`CLKGN_RATIO_W-1:0] wr_ratio;
  logic [`CLKGN_APB_DW-1:0]  rd_data;

  // access phase, no wait states
  assign acc      = psel & penable;
  assign pready   = 1'b1;
  assign wr_ratio = pwdata[`CLKGN_RATIO_W-1:0];

  // --------------------------------------------------------------------
  // address decode and read mux
  // --------------------------------------------------------------------
  always_comb
  begin
    addr_hit  = 1'b1;
    ratio_bad = 1'b0;
    rd_data   = '0;
    case (clkgn_pkg::reg_addr_e'(paddr))
      clkgn_pkg::REG_CDIV:
      begin
        rd_data[`CLKGN_RATIO_W-1:0] = cdiv;
        ratio_bad = wr_ratio < `CLKGN_RATIO_MIN;
      end
      clkgn_pkg::REG_DDIV:
      begin
        rd_data[`CLKGN_RATIO_W-1:0] = ddiv;
        ratio_bad = wr_ratio < `CLKGN_RATIO_MIN;
      end
      clkgn_pkg::REG_JDIV:
      begin
        rd_data[`CLKGN_RATIO_W-1:0] = jdiv;
        ratio_bad = wr_ratio < `CLKGN_RATIO_MIN;
      end
      clkgn_pkg::REG_STRETCH:
        rd_data[`CLKGN_STRETCH_W-1:0] = stretch_cnt;
      clkgn_pkg::REG_CTRL:
      begin
        // stretch bit is a pulse, reads back 0
        rd_data[clkgn_pkg::CTRL_START]   = start;
        rd_data[clkgn_pkg::CTRL_CMP_EN]  = cmp_en;
        rd_data[clkgn_pkg::CTRL_JBUS_EN] = jbus_en;
        rd_data[clkgn_pkg::CTRL_DRAM_EN] = dram_en;
      end
      default:
        addr_hit = 1'b0;
    endcase
  end

  assign prdata  = rd_data;
  // bad ratio only faults on writes
  assign pslverr = acc & (~addr_hit | (pwrite & ratio_bad));
  assign wr_ok   = acc & pwrite & addr_hit & ~ratio_bad;

  // --------------------------------------------------------------------
  // registers
  // --------------------------------------------------------------------
  always_ff @(posedge ctu_clsp or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cdiv        <= `CLKGN_RATIO_W'(`CLKGN_RATIO_MIN);
      ddiv        <= `CLKGN_RATIO_W'(`CLKGN_RATIO_MIN);
      jdiv        <= `CLKGN_RATIO_W'(`CLKGN_RATIO_MIN);
      stretch_cnt <= '0;
      start       <= 1'b0;
      cmp_en      <= 1'b0;
      jbus_en     <= 1'b0;
      dram_en     <= 1'b0;
      stretch_req <= 1'b0;
    end
    else
    begin
      // one cycle per write of a 1
      stretch_req <= 1'b0;
      if (wr_ok)
      begin
        case (clkgn_pkg::reg_addr_e'(paddr))
          clkgn_pkg::REG_CDIV:    cdiv <= wr_ratio;
          clkgn_pkg::REG_DDIV:    ddiv <= wr_ratio;
          clkgn_pkg::REG_JDIV:    jdiv <= wr_ratio;
          clkgn_pkg::REG_STRETCH: stretch_cnt <= pwdata[`CLKGN_STRETCH_W-1:0];
          clkgn_pkg::REG_CTRL:
          begin
            start       <= pwdata[clkgn_pkg::CTRL_START];
            cmp_en      <= pwdata[clkgn_pkg::CTRL_CMP_EN];
            jbus_en     <= pwdata[clkgn_pkg::CTRL_JBUS_EN];
            dram_en     <= pwdata[clkgn_pkg::CTRL_DRAM_EN];
            stretch_req <= pwdata[clkgn_pkg::CTRL_STRETCH];
          end
          default:
          begin
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/clkgn_start_seq.sv ====
// --------------------------------------------------------------------
// start sequencer
// start synchronizer, run fsm, staged bypass enable chain
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

module clkgn_start_seq (
  input  logic ctu_clsp,
  input  logic arst_n,
  input  logic start,
  output logic run,
  output logic cmp_bypass_en,
  output logic jbus_bypass_en
);

  logic [`CLKGN_SYNC_STAGES-1:0] sync_q;
  logic                          start_sync;
  clkgn_pkg::seq_state_e         state_q;
  clkgn_pkg::seq_state_e         state_d;
  // init delay chain behind run
  logic [2:0]                    run_dly_q;

  // --------------------------------------------------------------------
  // start synchronizer
  // --------------------------------------------------------------------
  always_ff @(posedge ctu_clsp or negedge arst_n)
  begin
    if (!arst_n)
      sync_q <= '0;
    else
      sync_q <= {sync_q[`CLKGN_SYNC_STAGES-2:0], start};
  end

  assign start_sync = sync_q[`CLKGN_SYNC_STAGES-1];

  // --------------------------------------------------------------------
  // run fsm
  // --------------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      clkgn_pkg::SEQ_IDLE:
        if (start_sync)
          state_d = clkgn_pkg::SEQ_RUN;
      clkgn_pkg::SEQ_RUN:
        if (!start_sync)
          state_d = clkgn_pkg::SEQ_SYNC;
      // stopping, wait for bypass to come back on
      clkgn_pkg::SEQ_SYNC:
        if (start_sync)
          state_d = clkgn_pkg::SEQ_RUN;
        else if (run_dly_q == '0)
          state_d = clkgn_pkg::SEQ_IDLE;
      default:
        state_d = clkgn_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge ctu_clsp or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q   <= clkgn_pkg::SEQ_IDLE;
      run_dly_q <= '0;
    end
    else
    begin
      state_q   <= state_d;
      run_dly_q <= {run_dly_q[1:0], run};
    end
  end

  assign run = (state_q == clkgn_pkg::SEQ_RUN);

  // bypass on before start, jbus drops first, cmp one cycle later
  assign jbus_bypass_en = ~run_dly_q[1];
  assign cmp_bypass_en  = ~run_dly_q[2];

endmodule

// ==== rtl/clkgn_domain_div.sv ====
// --------------------------------------------------------------------
// one domain divider
// programmable down counter, freezes on hold, one cycle tick
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

module clkgn_domain_div (
  input  logic                      ctu_clsp,
  input  logic                      arst_n,
  input  logic [`CLKGN_RATIO_W-1:0] ratio,
  input  logic                      enable,
  input  logic                      hold,
  output logic                      tick_raw
);

  logic [`CLKGN_RATIO_W-1:0] cnt_q;
  logic                      term;

  // count 1 is terminal
  // count 0 only while idle, loads ratio on the first enabled cycle
  assign term = (cnt_q == `CLKGN_RATIO_W'(1));

  // --------------------------------------------------------------------
  // counter
  // --------------------------------------------------------------------
  always_ff @(posedge ctu_clsp or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt_q <= '0;
    end
    else if (!enable)
    begin
      // held in init
      cnt_q <= '0;
    end
    else if (hold)
    begin
      // stretch, period grows by the hold length
      cnt_q <= cnt_q;
    end
    else if (term || cnt_q == '0)
    begin
      // wrap, new ratio picked up here
      cnt_q <= ratio;
    end
    else
    begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // tick waits out a hold that lands on the terminal count
  assign tick_raw = enable & ~hold & term;

endmodule

// ==== rtl/clkgn_stretch_ctl.sv ====
// --------------------------------------------------------------------
// clock stretch control
// request one-shot and hold cycle counter
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

module clkgn_stretch_ctl (
  input  logic                        ctu_clsp,
  input  logic                        arst_n,
  input  logic                        run,
  input  logic                        stretch_req,
  input  logic [`CLKGN_STRETCH_W-1:0] stretch_cnt,
  output logic                        hold
);

  clkgn_pkg::str_state_e       state_q;
  logic [`CLKGN_STRETCH_W-1:0] remain_q;
  logic                        req_q;
  logic                        req_1sht;

  // rising edge of request, only while dividers run
  assign req_1sht = stretch_req & ~req_q & run;

  // --------------------------------------------------------------------
  // hold counter
  // --------------------------------------------------------------------
  always_ff @(posedge ctu_clsp or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q  <= clkgn_pkg::STR_IDLE;
      remain_q <= '0;
      req_q    <= 1'b0;
    end
    else
    begin
      req_q <= stretch_req;
      case (state_q)
        clkgn_pkg::STR_IDLE:
          // zero count, nothing to stretch
          if (req_1sht && stretch_cnt != '0)
          begin
            state_q  <= clkgn_pkg::STR_HOLD;
            remain_q <= stretch_cnt;
          end
        clkgn_pkg::STR_HOLD:
        begin
          // requests in here are dropped
          remain_q <= remain_q - 1'b1;
          if (!run || remain_q == `CLKGN_STRETCH_W'(1))
            state_q <= clkgn_pkg::STR_IDLE;
        end
        default:
          state_q <= clkgn_pkg::STR_IDLE;
      endcase
    end
  end

  // high for exactly stretch_cnt cycles
  assign hold = (state_q == clkgn_pkg::STR_HOLD);

endmodule

// ==== rtl/clkgn_out_stage.sv ====
// --------------------------------------------------------------------
// output stage
// tick registers and jbus multiplier reset
// --------------------------------------------------------------------

module clkgn_out_stage (
  input  logic ctu_clsp,
  input  logic arst_n,
  input  logic run,
  input  logic cmp_tick_raw,
  input  logic jbus_tick_raw,
  input  logic dram_tick_raw,
  output logic cmp_tick,
  output logic jbus_tick,
  output logic dram_tick,
  output logic jbus_mult_rst_n
);

  // tick bits in ctrl enable order
  logic [clkgn_pkg::CTRL_DRAM_EN:clkgn_pkg::CTRL_CMP_EN] tick_q;
  logic                                                  mult_rst_n_q;

  always_ff @(posedge ctu_clsp or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_q       <= '0;
      mult_rst_n_q <= 1'b0;
    end
    else
    begin
      tick_q[clkgn_pkg::CTRL_CMP_EN]  <= cmp_tick_raw;
      tick_q[clkgn_pkg::CTRL_JBUS_EN] <= jbus_tick_raw;
      tick_q[clkgn_pkg::CTRL_DRAM_EN] <= dram_tick_raw;
      // released together with the first jbus tick, back in reset on stop
      if (!run)
        mult_rst_n_q <= 1'b0;
      else if (jbus_tick_raw)
        mult_rst_n_q <= 1'b1;
    end
  end

  assign cmp_tick        = tick_q[clkgn_pkg::CTRL_CMP_EN];
  assign jbus_tick       = tick_q[clkgn_pkg::CTRL_JBUS_EN];
  assign dram_tick       = tick_q[clkgn_pkg::CTRL_DRAM_EN];
  assign jbus_mult_rst_n = mult_rst_n_q;

endmodule

// ==== rtl/clkgn_top.sv ====
// --------------------------------------------------------------------
// clock divider control top
// csr, start sequencer, stretch, three dividers, output stage
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

module clkgn_top (
  input  logic                     ctu_clsp,
  input  logic                     arst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`CLKGN_APB_AW-1:0] paddr,
  input  logic [`CLKGN_APB_DW-1:0] pwdata,
  output logic [`CLKGN_APB_DW-1:0] prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     cmp_tick,
  output logic                     jbus_tick,
  output logic                     dram_tick,
  output logic                     cmp_bypass_en,
  output logic                     jbus_bypass_en,
  output logic                     jbus_mult_rst_n
);

  logic [`CLKGN_RATIO_W-1:0]   cdiv;
  logic [`CLKGN_RATIO_W-1:0]   ddiv;
  logic [`CLKGN_RATIO_W-1:0]   jdiv;
  logic [`CLKGN_STRETCH_W-1:0] stretch_cnt;
  logic                        start;
  logic                        cmp_en;
  logic                        jbus_en;
  logic                        dram_en;
  logic                        stretch_req;
  logic                        run;
  logic                        hold;
  logic [`CLKGN_NUM_DOM-1:0]   tick_raw;

  // --------------------------------------------------------------------
  // input side
  // --------------------------------------------------------------------
  clkgn_csr_apb u_csr (
    .ctu_clsp   (ctu_clsp),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .cdiv       (cdiv),
    .ddiv       (ddiv),
    .jdiv       (jdiv),
    .stretch_cnt(stretch_cnt),
    .start      (start),
    .cmp_en     (cmp_en),
    .jbus_en    (jbus_en),
    .dram_en    (dram_en),
    .stretch_req(stretch_req)
  );

  clkgn_start_seq u_seq (
    .ctu_clsp      (ctu_clsp),
    .arst_n        (arst_n),
    .start         (start),
    .run           (run),
    .cmp_bypass_en (cmp_bypass_en),
    .jbus_bypass_en(jbus_bypass_en)
  );

  // --------------------------------------------------------------------
  // processing, stretch and the domain dividers
  // --------------------------------------------------------------------
  clkgn_stretch_ctl u_str (
    .ctu_clsp   (ctu_clsp),
    .arst_n     (arst_n),
    .run        (run),
    .stretch_req(stretch_req),
    .stretch_cnt(stretch_cnt),
    .hold       (hold)
  );

  // each domain runs only with run and its own enable
  clkgn_domain_div u_cmp_div (
    .ctu_clsp(ctu_clsp),
    .arst_n  (arst_n),
    .ratio   (cdiv),
    .enable  (run & cmp_en),
    .hold    (hold),
    .tick_raw(tick_raw[0])
  );

  clkgn_domain_div u_jbus_div (
    .ctu_clsp(ctu_clsp),
    .arst_n  (arst_n),
    .ratio   (jdiv),
    .enable  (run & jbus_en),
    .hold    (hold),
    .tick_raw(tick_raw[1])
  );

  clkgn_domain_div u_dram_div (
    .ctu_clsp(ctu_clsp),
    .arst_n  (arst_n),
    .ratio   (ddiv),
    .enable  (run & dram_en),
    .hold    (hold),
    .tick_raw(tick_raw[2])
  );

  // --------------------------------------------------------------------
  // output side
  // --------------------------------------------------------------------
  clkgn_out_stage u_out (
    .ctu_clsp       (ctu_clsp),
    .arst_n         (arst_n),
    .run            (run),
    .cmp_tick_raw   (tick_raw[0]),
    .jbus_tick_raw  (tick_raw[1]),
    .dram_tick_raw  (tick_raw[2]),
    .cmp_tick       (cmp_tick),
    .jbus_tick      (jbus_tick),
    .dram_tick      (dram_tick),
    .jbus_mult_rst_n(jbus_mult_rst_n)
  );

endmodule

// ==== verif/clkgn_tb_clk.sv ====
// --------------------------------------------------------------------
// testbench clock and reset source
// --------------------------------------------------------------------

module clkgn_tb_clk (
  output logic ctu_clsp,
  output logic arst_n
);

  // 40 unit period
  initial
  begin
    ctu_clsp = 1'b0;
    forever #20 ctu_clsp = ~ctu_clsp;
  end

  // reset low for 2 cycles, released on a falling edge
  initial
  begin
    arst_n = 1'b0;
    repeat (2) @(posedge ctu_clsp);
    @(negedge ctu_clsp);
    arst_n = 1'b1;
  end

endmodule

// ==== verif/clkgn_tb.sv ====
// --------------------------------------------------------------------
// clock divider control testbench
// apb stimulus, register shadow, output monitor with assertions
// watchdog and final verdict
// --------------------------------------------------------------------

`include "clkgn_settings.svh"

module clkgn_tb;

  // each run is a few hundred cycles at most
  localparam int MAX_CYCLES = 4000;

  logic                        ctu_clsp;
  logic                        arst_n;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [`CLKGN_APB_AW-1:0]    paddr;
  logic [`CLKGN_APB_DW-1:0]    pwdata;
  logic [`CLKGN_APB_DW-1:0]    prdata;
  logic                        pready;
  logic                        pslverr;
  logic                        cmp_tick;
  logic                        jbus_tick;
  logic                        dram_tick;
  logic                        cmp_bypass_en;
  logic                        jbus_bypass_en;
  logic                        jbus_mult_rst_n;

  // register shadow, domain index 0 cmp, 1 jbus, 2 dram
  logic [`CLKGN_RATIO_W-1:0]   ratio_m [3];
  logic [`CLKGN_STRETCH_W-1:0] str_m;
  logic                        start_m;
  logic [2:0]                  en_m;
  logic                        str_pend;

  // monitor state
  int                          cyc;
  logic [2:0]                  start_hist;
  logic [2:0]                  run_hist;
  logic                        run_d;
  logic [2:0]                  en_d;
  int                          hold_left;
  logic                        hold_d;
  logic                        mr_model;
  int                          last_tick [3];
  int                          acc [3];
  logic [2:0]                  seen;
  int                          tick_cnt [3];
  int                          stretched [3];
  int                          mr_rise;
  int                          ignored_req;

  clkgn_tb_clk u_clk (
    .ctu_clsp(ctu_clsp),
    .arst_n  (arst_n)
  );

  clkgn_top uut (
    .ctu_clsp       (ctu_clsp),
    .arst_n         (arst_n),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .cmp_tick       (cmp_tick),
    .jbus_tick      (jbus_tick),
    .dram_tick      (dram_tick),
    .cmp_bypass_en  (cmp_bypass_en),
    .jbus_bypass_en (jbus_bypass_en),
    .jbus_mult_rst_n(jbus_mult_rst_n)
  );

  // --------------------------------------------------------------------
  // failure reporting
  // --------------------------------------------------------------------
  task automatic stop_failed();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    stop_failed();
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  // --------------------------------------------------------------------
  // register map helpers
  // --------------------------------------------------------------------
  function automatic logic is_ratio_reg(input logic [`CLKGN_APB_AW-1:0] addr);
    return addr == clkgn_pkg::REG_CDIV || addr == clkgn_pkg::REG_DDIV ||
           addr == clkgn_pkg::REG_JDIV;
  endfunction

  function automatic logic is_mapped(input logic [`CLKGN_APB_AW-1:0] addr);
    return is_ratio_reg(addr) || addr == clkgn_pkg::REG_STRETCH ||
           addr == clkgn_pkg::REG_CTRL;
  endfunction

  function automatic logic [`CLKGN_APB_AW-1:0] dom_addr(input int d);
    if (d == 0)
      return clkgn_pkg::REG_CDIV;
    else if (d == 1)
      return clkgn_pkg::REG_JDIV;
    else
      return clkgn_pkg::REG_DDIV;
  endfunction

  function automatic string dom_name(input int d);
    if (d == 0)
      return "cmp";
    else if (d == 1)
      return "jbus";
    else
      return "dram";
  endfunction

  // legal ratio, min up to the largest the field holds
  function automatic logic [31:0] rand_ratio();
    return `CLKGN_RATIO_MIN + $urandom % ((1 << `CLKGN_RATIO_W) - `CLKGN_RATIO_MIN);
  endfunction

  function automatic logic [31:0] ctrl_word(input logic start, input logic [2:0] en,
                                            input logic stretch);
    logic [31:0] w;
    w = '0;
    w[clkgn_pkg::CTRL_START]   = start;
    w[clkgn_pkg::CTRL_CMP_EN]  = en[0];
    w[clkgn_pkg::CTRL_JBUS_EN] = en[1];
    w[clkgn_pkg::CTRL_DRAM_EN] = en[2];
    w[clkgn_pkg::CTRL_STRETCH] = stretch;
    return w;
  endfunction

  // read value from the shadow, stretch bit always 0
  function automatic logic [31:0] expected_read(input logic [`CLKGN_APB_AW-1:0] addr);
    logic [31:0] data;
    data = '0;
    case (addr)
      clkgn_pkg::REG_CDIV:    data[`CLKGN_RATIO_W-1:0] = ratio_m[0];
      clkgn_pkg::REG_JDIV:    data[`CLKGN_RATIO_W-1:0] = ratio_m[1];
      clkgn_pkg::REG_DDIV:    data[`CLKGN_RATIO_W-1:0] = ratio_m[2];
      clkgn_pkg::REG_STRETCH: data[`CLKGN_STRETCH_W-1:0] = str_m;
      clkgn_pkg::REG_CTRL:
      begin
        data[clkgn_pkg::CTRL_START]   = start_m;
        data[clkgn_pkg::CTRL_CMP_EN]  = en_m[0];
        data[clkgn_pkg::CTRL_JBUS_EN] = en_m[1];
        data[clkgn_pkg::CTRL_DRAM_EN] = en_m[2];
      end
      default:
        data = '0;
    endcase
    return data;
  endfunction

  // --------------------------------------------------------------------
  // apb tasks, setup and access on falling edges
  // --------------------------------------------------------------------
  task automatic write_reg(input string name, input logic [`CLKGN_APB_AW-1:0] addr,
                           input logic [31:0] data);
    logic exp_err;
    logic err;
    logic rdy;
    exp_err = !is_mapped(addr) ||
              (is_ratio_reg(addr) && data[`CLKGN_RATIO_W-1:0] < `CLKGN_RATIO_MIN);
    @(negedge ctu_clsp);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge ctu_clsp);
    penable = 1'b1;
    // access edge, shadow follows the register file here
    @(posedge ctu_clsp);
    err = pslverr;
    rdy = pready;
    if (!exp_err)
    begin
      case (addr)
        clkgn_pkg::REG_CDIV:    ratio_m[0] = data[`CLKGN_RATIO_W-1:0];
        clkgn_pkg::REG_JDIV:    ratio_m[1] = data[`CLKGN_RATIO_W-1:0];
        clkgn_pkg::REG_DDIV:    ratio_m[2] = data[`CLKGN_RATIO_W-1:0];
        clkgn_pkg::REG_STRETCH: str_m = data[`CLKGN_STRETCH_W-1:0];
        default:
        begin
          start_m  = data[clkgn_pkg::CTRL_START];
          en_m     = {data[clkgn_pkg::CTRL_DRAM_EN], data[clkgn_pkg::CTRL_JBUS_EN],
                      data[clkgn_pkg::CTRL_CMP_EN]};
          str_pend = data[clkgn_pkg::CTRL_STRETCH];
        end
      endcase
    end
    @(negedge ctu_clsp);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    assert (rdy == 1'b1) else report_mismatch({name, " pready"}, 1, rdy);
    assert (err == exp_err) else report_mismatch({name, " pslverr"}, exp_err, err);
  endtask

  task automatic read_reg(input string name, input logic [`CLKGN_APB_AW-1:0] addr);
    logic        exp_err;
    logic        err;
    logic [31:0] exp_data;
    logic [31:0] data;
    exp_err = !is_mapped(addr);
    @(negedge ctu_clsp);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    pwdata  = '0;
    @(negedge ctu_clsp);
    penable = 1'b1;
    @(posedge ctu_clsp);
    err      = pslverr;
    data     = prdata;
    exp_data = expected_read(addr);
    @(negedge ctu_clsp);
    psel    = 1'b0;
    penable = 1'b0;
    assert (err == exp_err) else report_mismatch({name, " pslverr"}, exp_err, err);
    assert (data == exp_data) else report_mismatch(name, exp_data, data);
  endtask

  // counters move on falling edges, polled on rising ones
  task automatic wait_ticks(input int d, input int n);
    int target;
    target = tick_cnt[d] + n;
    do
      @(posedge ctu_clsp);
    while (tick_cnt[d] < target);
  endtask

  task automatic wait_idle();
    do
      @(negedge ctu_clsp);
    while (!(cmp_bypass_en && jbus_bypass_en && !jbus_mult_rst_n));
  endtask

  // --------------------------------------------------------------------
  // monitor, samples registered outputs on the falling edge
  // --------------------------------------------------------------------
  always @(negedge ctu_clsp)
  begin : monitor
    logic       run_now;
    logic       cur_hold;
    logic [2:0] tick_v;
    int         exp_gap;
    // models start out of reset
    if (arst_n === 1'b1)
    begin
      cyc++;
      // run follows start through sync and fsm, 3 cycles
      run_now = start_hist[2];
      assert (uut.run == run_now) else report_mismatch("run", run_now, uut.run);
      // staged bypass release
      assert (jbus_bypass_en == !run_hist[1])
        else report_mismatch("jbus_bypass", !run_hist[1], jbus_bypass_en);
      assert (cmp_bypass_en == !run_hist[2])
        else report_mismatch("cmp_bypass", !run_hist[2], cmp_bypass_en);

      // stretch model, request seen one cycle after the write
      cur_hold = (hold_left != 0);
      if (cur_hold)
        hold_left--;
      if (str_pend)
      begin
        if (cur_hold)
          ignored_req++;
        else if (run_now && str_m != '0)
          hold_left = str_m;
        str_pend = 1'b0;
      end
      assert (uut.hold == cur_hold) else report_mismatch("hold", cur_hold, uut.hold);

      // tick spacing, output lags raw by one cycle
      tick_v = {dram_tick, jbus_tick, cmp_tick};
      for (int d = 0; d < 3; d++)
      begin
        if (tick_v[d])
        begin
          assert (run_d && en_d[d])
            else report_mismatch({dom_name(d), " tick while off"}, 0, 1);
          exp_gap = int'(ratio_m[d]) + acc[d] + (seen[d] ? 0 : 1);
          assert (cyc - last_tick[d] == exp_gap)
            else report_mismatch({dom_name(d), " tick gap"}, exp_gap, cyc - last_tick[d]);
          if (acc[d] != 0)
            stretched[d]++;
          tick_cnt[d]++;
          last_tick[d] = cyc;
          seen[d]      = 1'b1;
          acc[d]       = 0;
        end
        else
          acc[d] += hold_d;
      end
      // first tick counted from the rise of run
      if (run_now && !run_d)
      begin
        for (int d = 0; d < 3; d++)
        begin
          last_tick[d] = cyc;
          acc[d]       = 0;
          seen[d]      = 1'b0;
        end
      end

      // multiplier reset released with the first jbus tick
      if (!run_d)
        mr_model = 1'b0;
      else if (jbus_tick)
      begin
        if (!mr_model)
          mr_rise++;
        mr_model = 1'b1;
      end
      assert (jbus_mult_rst_n == mr_model)
        else report_mismatch("jbus_mult_rst_n", mr_model, jbus_mult_rst_n);

      start_hist = {start_hist[1:0], start_m};
      run_hist   = {run_hist[1:0], run_now};
      run_d      = run_now;
      en_d       = en_m;
      hold_d     = cur_hold;
    end
  end

  // --------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------
  initial
  begin : watchdog
    repeat (MAX_CYCLES) @(posedge ctu_clsp);
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    stop_failed();
  end

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------
  initial
  begin : stimulus
    logic [31:0] s;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    str_m       = '0;
    start_m     = 1'b0;
    en_m        = '0;
    str_pend    = 1'b0;
    cyc         = 0;
    start_hist  = '0;
    run_hist    = '0;
    run_d       = 1'b0;
    en_d        = '0;
    hold_left   = 0;
    hold_d      = 1'b0;
    mr_model    = 1'b0;
    seen        = '0;
    mr_rise     = 0;
    ignored_req = 0;
    for (int d = 0; d < 3; d++)
    begin
      ratio_m[d]   = `CLKGN_RATIO_W'(`CLKGN_RATIO_MIN);
      last_tick[d] = 0;
      acc[d]       = 0;
      tick_cnt[d]  = 0;
      stretched[d] = 0;
    end
    void'($urandom(71));
    wait (arst_n === 1'b1);

    // registers, random ratios and error responses
    for (int d = 0; d < 3; d++)
      write_reg({dom_name(d), " ratio wr"}, dom_addr(d), rand_ratio());
    write_reg("stretch wr", clkgn_pkg::REG_STRETCH, $urandom % 16);
    for (int d = 0; d < 3; d++)
      read_reg({dom_name(d), " ratio rd"}, dom_addr(d));
    read_reg("stretch rd", clkgn_pkg::REG_STRETCH);
    read_reg("ctrl rd", clkgn_pkg::REG_CTRL);
    write_reg("cdiv ratio 1", clkgn_pkg::REG_CDIV, 32'd1);
    write_reg("unmapped wr", 8'h14, 32'h5);
    read_reg("unmapped rd", 8'h14);
    for (int d = 0; d < 3; d++)
      read_reg({dom_name(d), " ratio after err"}, dom_addr(d));

    // first run, dram left disabled
    write_reg("start cmp jbus", clkgn_pkg::REG_CTRL, ctrl_word(1'b1, 3'b011, 1'b0));
    wait_ticks(0, 4);
    wait_ticks(1, 4);
    read_reg("ctrl running", clkgn_pkg::REG_CTRL);
    write_reg("stop 1", clkgn_pkg::REG_CTRL, ctrl_word(1'b0, 3'b011, 1'b0));
    wait_idle();

    // second run, all domains with a stretch
    for (int d = 0; d < 3; d++)
      write_reg({dom_name(d), " ratio run 2"}, dom_addr(d), rand_ratio());
    s = 3 + $urandom % 5;
    write_reg("stretch count", clkgn_pkg::REG_STRETCH, s);
    write_reg("start all", clkgn_pkg::REG_CTRL, ctrl_word(1'b1, 3'b111, 1'b0));
    for (int d = 0; d < 3; d++)
      wait_ticks(d, 2);
    write_reg("stretch req", clkgn_pkg::REG_CTRL, ctrl_word(1'b1, 3'b111, 1'b1));
    // lands inside the hold
    write_reg("stretch req again", clkgn_pkg::REG_CTRL, ctrl_word(1'b1, 3'b111, 1'b1));
    for (int d = 0; d < 3; d++)
      wait_ticks(d, 3);
    write_reg("stop 2", clkgn_pkg::REG_CTRL, ctrl_word(1'b0, 3'b111, 1'b0));
    wait_idle();

    // every behavior actually reached
    for (int d = 0; d < 3; d++)
      if (stretched[d] == 0)
        report_error({"no stretched period was seen on the ", dom_name(d), " domain"});
    if (ignored_req == 0)
      report_error("the second stretch request did not arrive during the hold");
    if (mr_rise != 2)
      report_error("jbus multiplier reset was not released once per run");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/clkgn_pkg.sv
rtl/clkgn_csr_apb.sv
rtl/clkgn_start_seq.sv
rtl/clkgn_domain_div.sv
rtl/clkgn_stretch_ctl.sv
rtl/clkgn_out_stage.sv
rtl/clkgn_top.sv
verif/clkgn_tb_clk.sv
verif/clkgn_tb.sv

// ==== Bender.yml ====
package:
  name: clkgn

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/clkgn_pkg.sv
      - rtl/clkgn_csr_apb.sv
      - rtl/clkgn_start_seq.sv
      - rtl/clkgn_domain_div.sv
      - rtl/clkgn_stretch_ctl.sv
      - rtl/clkgn_out_stage.sv
      - rtl/clkgn_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/clkgn_tb_clk.sv
      - verif/clkgn_tb.sv
